/* design/core_cfg_pkg.sv */
package core_cfg_pkg;

  // datapath width
  localparam int XLEN = 32;

  // architectural register file
  localparam int NUM_REGS   = 32;
  localparam int REG_ADDR_W = $clog2(NUM_REGS);  // 5 bits for x0..x31

endpackage

/* design/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
  input  logic                               instr_valid,
  input  rv_isa_pkg::rv_instr_u              instr,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0] rs1,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0] rs2,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0] rd,
  output logic                               writes_rd,
  output logic                               uses_rs2
);
  import rv_isa_pkg::*;

  logic [6:0] opcode;
  logic       is_rr;      // register-register format
  logic       known_opc;
  logic       no_rd;      // stores and branches

  always_comb begin
    opcode    = instr.r.opcode;  // same bits in both views
    is_rr     = (opcode == OPC_OP);
    known_opc = opcode inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_STORE, OPC_BRANCH};
    no_rd     = (opcode == OPC_STORE) || (opcode == OPC_BRANCH);
    // second source exists for reg-reg ops, stores and branches
    uses_rs2  = is_rr || no_rd;

    // lui carries only an immediate, so it has no first source
    if (opcode == OPC_LUI) begin
      rs1 = '0;
    end else begin
      rs1 = instr.i.rs1;  // rs1 and rd sit at the same place in both views
    end
    rs2 = uses_rs2 ? instr.r.rs2 : '0;  // otherwise these bits are imm12
    rd  = no_rd ? '0 : instr.i.rd;  // store/branch slot is imm

    // x0 never gets renamed
    writes_rd = instr_valid && known_opc && (rd != '0);
  end

  // unsupported words must not reach rename
  always_comb begin
    if (instr_valid) begin
      assert (known_opc)
        else $error("instr_decode: unknown opcode %b", opcode);
    end
  end

endmodule

/* design/operand_fetch.sv */
`timescale 1ns/1ps

module operand_fetch #(
  parameter  int ROB_DEPTH = 8,
  localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
  input  logic [core_cfg_pkg::XLEN-1:0]                 rval1,
  input  logic [core_cfg_pkg::XLEN-1:0]                 rval2,
  input  logic [TAG_W-1:0]                              tag1,
  input  logic [TAG_W-1:0]                              tag2,
  input  logic                                          tag1_valid,
  input  logic                                          tag2_valid,
  input  logic [ROB_DEPTH-1:0]                          entry_done,
  input  logic [ROB_DEPTH-1:0][core_cfg_pkg::XLEN-1:0]  entry_value,
  output logic [core_cfg_pkg::XLEN-1:0]                 op1_value,
  output logic [core_cfg_pkg::XLEN-1:0]                 op2_value,
  output logic                                          op1_ready,
  output logic                                          op2_ready,
  output logic [TAG_W-1:0]                              op1_tag,
  output logic [TAG_W-1:0]                              op2_tag
);
  import core_cfg_pkg::*;

  // committed value, forwarded buffer value, or wait on the tag
  function automatic void resolve(
    input  logic [XLEN-1:0]  rval,
    input  logic [TAG_W-1:0] tag,
    input  logic             tag_valid,
    output logic [XLEN-1:0]  value,
    output logic             ready,
    output logic [TAG_W-1:0] tag_out
  );
    tag_out = tag_valid ? tag : '0;  // stale tags are hidden
    if (!tag_valid) begin
      ready = 1'b1;
      value = rval;
    end else if (entry_done[tag]) begin
      ready = 1'b1;
      value = entry_value[tag];  // result done but not yet retired
    end else begin
      ready = 1'b0;
      value = '0;  // consumer waits for the cdb
    end
  endfunction

  always_comb begin
    resolve(rval1, tag1, tag1_valid, op1_value, op1_ready, op1_tag);
    resolve(rval2, tag2, tag2_valid, op2_value, op2_ready, op2_tag);
  end

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps

module register_file #(
  parameter  int ROB_DEPTH = 8,
  localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
  input  logic                                clk_in,
  input  logic                                rst_in,
  input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rs1,
  input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rs2,
  // retirement writeback
  input  logic                                we,
  input  logic [core_cfg_pkg::REG_ADDR_W-1:0] wa,
  input  logic [core_cfg_pkg::XLEN-1:0]       wd,
  input  logic [TAG_W-1:0]                    wtag,  // tag of the retiring entry
  // rename on dispatch
  input  logic                                issue,
  input  logic [core_cfg_pkg::REG_ADDR_W-1:0] issue_rd,
  input  logic [TAG_W-1:0]                    issue_tag,
  // flush clears the tags the buffer still owns
  input  logic                                flush,
  input  logic [ROB_DEPTH-1:0][core_cfg_pkg::REG_ADDR_W-1:0] flush_addrs,
  input  logic [ROB_DEPTH-1:0]                flush_mask,
  output logic [core_cfg_pkg::XLEN-1:0]       rval1,
  output logic [core_cfg_pkg::XLEN-1:0]       rval2,
  output logic [TAG_W-1:0]                    tag1,
  output logic [TAG_W-1:0]                    tag2,
  output logic                                tag1_valid,
  output logic                                tag2_valid
);
  import core_cfg_pkg::*;

  logic [XLEN-1:0]     regs [NUM_REGS];   // committed values
  logic [TAG_W-1:0]    tags [NUM_REGS];   // youngest in-flight writer
  logic [NUM_REGS-1:0] tag_valid;         // 1 = value still being produced

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
        tags[i] <= '0;
      end
      tag_valid <= '0;
    end else if (flush) begin
      // committed values stay, only pending renames are dropped
      for (int j = 0; j < ROB_DEPTH; j++) begin
        if (flush_mask[j]) begin
          tags[flush_addrs[j]]      <= '0;
          tag_valid[flush_addrs[j]] <= 1'b0;
        end
      end
    end else begin
      if (we && (wa != '0)) begin
        regs[wa] <= wd;  // in-order retire, so always the newest committed value
        // a younger writer keeps its tag
        if (tag_valid[wa] && (tags[wa] == wtag)) begin
          tags[wa]      <= '0;
          tag_valid[wa] <= 1'b0;
        end
      end
      // issue comes last so it wins over a same-edge writeback
      if (issue) begin
        tags[issue_rd]      <= issue_tag;
        tag_valid[issue_rd] <= 1'b1;
      end
    end
  end

  always_comb begin
    rval1      = regs[rs1];
    rval2      = regs[rs2];
    tag1       = tags[rs1];
    tag2       = tags[rs2];
    tag1_valid = tag_valid[rs1];
    tag2_valid = tag_valid[rs2];
  end

  // the buffer must never rename x0
  a_x0_no_tag: assert property (@(posedge clk_in) disable iff (rst_in) !tag_valid[0])
    else $error("register_file: x0 holds a valid tag");

endmodule

/* design/rename_core.sv */
`timescale 1ns/1ps

module rename_core #(
  parameter  int ROB_DEPTH = 8,
  localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
  input  logic                                clk_in,
  input  logic                                rst_in,
  input  logic                                instr_valid,
  input  rv_isa_pkg::rv_instr_u               instr,
  input  logic                                cdb_valid,
  input  logic [TAG_W-1:0]                    cdb_tag,
  input  logic [core_cfg_pkg::XLEN-1:0]       cdb_data,
  input  logic                                flush,
  output logic                                stall,  // buffer full
  output logic [core_cfg_pkg::XLEN-1:0]       op1_value,
  output logic                                op1_ready,
  output logic [TAG_W-1:0]                    op1_tag,
  output logic [core_cfg_pkg::XLEN-1:0]       op2_value,
  output logic                                op2_ready,
  output logic [TAG_W-1:0]                    op2_tag,
  output logic                                commit_valid,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0] commit_rd,
  output logic [core_cfg_pkg::XLEN-1:0]       commit_data
);
  import core_cfg_pkg::*;

  logic [REG_ADDR_W-1:0]                dec_rs1, dec_rs2, dec_rd;
  logic                                 dec_writes_rd;
  logic [TAG_W-1:0]                     alloc_tag;
  logic                                 rf_issue, rf_we;
  logic [REG_ADDR_W-1:0]                rf_wa;
  logic [XLEN-1:0]                      rf_wd;
  logic [TAG_W-1:0]                     rf_wtag;
  logic [ROB_DEPTH-1:0][REG_ADDR_W-1:0] flush_addrs;
  logic [ROB_DEPTH-1:0]                 flush_mask;
  logic [XLEN-1:0]                      rval1, rval2;
  logic [TAG_W-1:0]                     tag1, tag2;
  logic                                 tag1_valid, tag2_valid;
  logic [ROB_DEPTH-1:0]                 entry_done;
  logic [ROB_DEPTH-1:0][XLEN-1:0]       entry_value;

  instr_decode instr_decode_i (
    .instr_valid(instr_valid), .instr(instr),
    .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
    .writes_rd(dec_writes_rd), .uses_rs2()  // forcing of rs2 happens inside
  );

  register_file #(.ROB_DEPTH(ROB_DEPTH)) register_file_i (
    .clk_in(clk_in), .rst_in(rst_in), .rs1(dec_rs1), .rs2(dec_rs2),
    .we(rf_we), .wa(rf_wa), .wd(rf_wd), .wtag(rf_wtag),
    .issue(rf_issue), .issue_rd(dec_rd), .issue_tag(alloc_tag),
    .flush(flush), .flush_addrs(flush_addrs), .flush_mask(flush_mask),
    .rval1(rval1), .rval2(rval2), .tag1(tag1), .tag2(tag2),
    .tag1_valid(tag1_valid), .tag2_valid(tag2_valid)
  );

  reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) reorder_buffer_i (
    .clk_in(clk_in), .rst_in(rst_in),
    .alloc(instr_valid), .alloc_rd(dec_rd), .alloc_writes_rd(dec_writes_rd),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data), .flush(flush),
    .full(stall), .alloc_tag(alloc_tag),
    .rf_issue(rf_issue), .rf_we(rf_we), .rf_wa(rf_wa), .rf_wd(rf_wd), .rf_wtag(rf_wtag),
    .flush_addrs(flush_addrs), .flush_mask(flush_mask),
    .entry_done(entry_done), .entry_value(entry_value),
    .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data)
  );

  operand_fetch #(.ROB_DEPTH(ROB_DEPTH)) operand_fetch_i (
    .rval1(rval1), .rval2(rval2), .tag1(tag1), .tag2(tag2),
    .tag1_valid(tag1_valid), .tag2_valid(tag2_valid),
    .entry_done(entry_done), .entry_value(entry_value),
    .op1_value(op1_value), .op2_value(op2_value),
    .op1_ready(op1_ready), .op2_ready(op2_ready),
    .op1_tag(op1_tag), .op2_tag(op2_tag)
  );

endmodule

/* design/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer #(
  parameter  int ROB_DEPTH = 8,
  localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
  input  logic                                clk_in,
  input  logic                                rst_in,
  input  logic                                alloc,
  input  logic [core_cfg_pkg::REG_ADDR_W-1:0] alloc_rd,
  input  logic                                alloc_writes_rd,
  input  logic                                cdb_valid,
  input  logic [TAG_W-1:0]                    cdb_tag,
  input  logic [core_cfg_pkg::XLEN-1:0]       cdb_data,
  input  logic                                flush,
  output logic                                full,
  output logic [TAG_W-1:0]                    alloc_tag,
  output logic                                rf_issue,
  output logic                                rf_we,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0] rf_wa,
  output logic [core_cfg_pkg::XLEN-1:0]       rf_wd,
  output logic [TAG_W-1:0]                    rf_wtag,
  output logic [ROB_DEPTH-1:0][core_cfg_pkg::REG_ADDR_W-1:0] flush_addrs,
  output logic [ROB_DEPTH-1:0]                flush_mask,
  output logic [ROB_DEPTH-1:0]                entry_done,
  output logic [ROB_DEPTH-1:0][core_cfg_pkg::XLEN-1:0] entry_value,
  output logic                                commit_valid,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0] commit_rd,
  output logic [core_cfg_pkg::XLEN-1:0]       commit_data
);
  import core_cfg_pkg::*;

  logic [TAG_W:0]                       head, tail;  // msb is the wrap bit
  logic [TAG_W-1:0]                     head_idx, tail_idx;
  logic [ROB_DEPTH-1:0]                 busy, done;
  logic [ROB_DEPTH-1:0]                 wr_rd;       // entry writes a register
  logic [ROB_DEPTH-1:0][REG_ADDR_W-1:0] rd_q;
  logic [ROB_DEPTH-1:0][XLEN-1:0]       value_q;
  logic                                 empty, do_alloc, retire;

  always_comb begin
    head_idx  = head[TAG_W-1:0];
    tail_idx  = tail[TAG_W-1:0];
    empty     = (head == tail);
    full      = (head[TAG_W] != tail[TAG_W]) && (head_idx == tail_idx);
    alloc_tag = tail_idx;
    do_alloc  = alloc && !full && !flush;  // flush beats everything
    retire    = !empty && busy[head_idx] && done[head_idx] && !flush;

    rf_issue = do_alloc && alloc_writes_rd;
    rf_we    = retire && wr_rd[head_idx];
    rf_wa    = rd_q[head_idx];
    rf_wd    = value_q[head_idx];
    rf_wtag  = head_idx;

    // every live renaming entry names a register to release
    flush_addrs = rd_q;
    flush_mask  = busy & wr_rd;
    entry_done  = done;
    entry_value = value_q;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head         <= '0;
      tail         <= '0;
      busy         <= '0;
      done         <= '0;
      commit_valid <= 1'b0;
    end else if (flush) begin
      head         <= '0;  // empty, tags restart at 0
      tail         <= '0;
      busy         <= '0;
      done         <= '0;
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= retire;  // one pulse per retirement
      if (retire) begin
        busy[head_idx] <= 1'b0;
        done[head_idx] <= 1'b0;
        head           <= head + 1'b1;
      end
      if (cdb_valid) begin
        done[cdb_tag] <= 1'b1;
      end
      if (do_alloc) begin
        busy[tail_idx] <= 1'b1;
        done[tail_idx] <= 1'b0;
        tail           <= tail + 1'b1;
      end
    end
  end

  // payload, only meaningful while busy
  always_ff @(posedge clk_in) begin
    if (retire) begin
      commit_rd   <= rd_q[head_idx];
      commit_data <= value_q[head_idx];
    end
    if (cdb_valid) value_q[cdb_tag] <= cdb_data;
    if (do_alloc) begin
      rd_q[tail_idx]  <= alloc_rd;
      wr_rd[tail_idx] <= alloc_writes_rd;
    end
  end

  // execution side may only complete live, unfinished entries
  a_cdb_live: assert property (@(posedge clk_in) disable iff (rst_in || flush)
    cdb_valid |-> busy[cdb_tag] && !done[cdb_tag])
    else $error("reorder_buffer: completion for tag %0d not pending", cdb_tag);

  // dispatch has to honour stall
  a_no_alloc_full: assert property (@(posedge clk_in) disable iff (rst_in)
    alloc |-> !full)
    else $error("reorder_buffer: alloc while full");

endmodule

/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

  // one 32-bit word, read either as register-register or as immediate format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;  // sign-extended later by the ALU side
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } rv_instr_u;

  // major opcodes handled by the rename stage
  localparam logic [6:0] OPC_OP     = 7'b0110011;  // add, sub, and ...
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // addi, andi ...
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;  // no rd
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;  // no rd

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the rename core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module rename_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vrename_core_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides pass or fail
if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
fi
exit 1

/* test/rename_core_tb.sv */
`timescale 1ns/1ps

module rename_core_tb;
  import core_cfg_pkg::*;

  localparam int ROB_DEPTH      = 8;
  localparam int TAG_W          = $clog2(ROB_DEPTH);
  localparam int COMMIT_TIMEOUT = 50;  // cycles
  localparam logic [31:0] FLUSH_DATA = 32'h5a5a_0005;  // must never reach a register

  logic                  clk_in;
  logic                  rst_in;
  logic                  instr_valid;
  logic [XLEN-1:0]       instr;
  logic                  cdb_valid;
  logic [TAG_W-1:0]      cdb_tag;
  logic [XLEN-1:0]       cdb_data;
  logic                  flush;
  logic                  stall;
  logic [XLEN-1:0]       op1_value, op2_value;
  logic                  op1_ready, op2_ready;
  logic [TAG_W-1:0]      op1_tag, op2_tag;
  logic                  commit_valid;
  logic [REG_ADDR_W-1:0] commit_rd;
  logic [XLEN-1:0]       commit_data;

  int          fd;    // golden file handle
  int          step;  // command number, shows up in error lines
  logic [7:0]  cmd;   // command letter
  logic [31:0] f0, f1, f2, f3, f4, f5, f6;  // hex fields of the current command
  int          disp_count;    // accepted dispatches since reset or flush
  int          commit_count;  // commits seen since reset or flush

  rename_core #(.ROB_DEPTH(ROB_DEPTH)) rename_core_i (
    .clk_in(clk_in), .rst_in(rst_in), .instr_valid(instr_valid), .instr(instr),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data), .flush(flush),
    .stall(stall),
    .op1_value(op1_value), .op1_ready(op1_ready), .op1_tag(op1_tag),
    .op2_value(op2_value), .op2_ready(op2_ready), .op2_tag(op2_tag),
    .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data)
  );

  initial begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;  // 20 ns period
  end

  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at command %0d", step);
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR cmd %0d %s: expected %h, actual %h", step, what, expected, actual);
      stop_run();
    end
  endtask

  task automatic bad_line();
    $display("golden file command %0d has missing or malformed fields", step);
    stop_run();
  endtask

  // rest of a comment line
  task automatic skip_line();
    int ch;
    ch = $fgetc(fd);
    while (ch != 10 && ch != -1) begin  // newline or end of file
      ch = $fgetc(fd);
    end
  endtask

  task automatic go_idle();
    @(posedge clk_in);
    instr_valid <= 1'b0;
    cdb_valid   <= 1'b0;
    flush       <= 1'b0;
  endtask

  // operands are combinational, so they are checked before the accept edge
  task automatic dispatch();
    @(posedge clk_in);
    instr_valid <= 1'b1;
    instr       <= f0;
    cdb_valid   <= 1'b0;
    flush       <= 1'b0;
    @(negedge clk_in);
    check_value("stall before dispatch", 32'd0, 32'(stall));
    check_value("op1_value", f1, op1_value);
    check_value("op1_ready", f2, 32'(op1_ready));
    check_value("op1_tag", f3, 32'(op1_tag));
    check_value("op2_value", f4, op2_value);
    check_value("op2_ready", f5, 32'(op2_ready));
    check_value("op2_tag", f6, 32'(op2_tag));
    disp_count++;
  endtask

  task automatic complete();
    @(posedge clk_in);
    instr_valid <= 1'b0;
    cdb_valid   <= 1'b1;  // one-cycle result bus pulse
    cdb_tag     <= f0[TAG_W-1:0];
    cdb_data    <= f1;
    flush       <= 1'b0;
  endtask

  task automatic wait_commit();
    int cycles;
    cycles = 0;
    go_idle();
    @(negedge clk_in);
    while (!commit_valid) begin
      if (cycles == COMMIT_TIMEOUT) begin
        $display("cmd %0d: no commit arrived within %0d cycles", step, COMMIT_TIMEOUT);
        stop_run();
      end else begin
        cycles++;
        @(negedge clk_in);
      end
    end
    check_value("commit_rd", f0, 32'(commit_rd));
    check_value("commit_data", f1, commit_data);
    commit_count++;
  endtask

  // the oldest pending entry is made done first, so the flush has to beat its retirement
  task automatic do_flush();
    @(posedge clk_in);
    instr_valid <= 1'b0;
    if (disp_count > commit_count) begin
      cdb_valid <= 1'b1;
      cdb_tag   <= TAG_W'(commit_count % ROB_DEPTH);  // tags are handed out in order
      cdb_data  <= FLUSH_DATA;
      @(posedge clk_in);
    end
    cdb_valid <= 1'b0;
    flush     <= 1'b1;
    go_idle();  // buffer empties on this edge
    @(negedge clk_in);
    check_value("commit after flush", 32'd0, 32'(commit_valid));
    disp_count   = 0;  // tags restart at 0
    commit_count = 0;
  endtask

  task automatic expect_stall();
    go_idle();
    @(negedge clk_in);
    check_value("stall", 32'd1, 32'(stall));
  endtask

  initial begin
    rst_in       = 1'b1;
    instr_valid  = 1'b0;
    instr        = '0;
    cdb_valid    = 1'b0;
    cdb_tag      = '0;
    cdb_data     = '0;
    flush        = 1'b0;
    step         = 0;
    disp_count   = 0;
    commit_count = 0;
    fd = $fopen("test/rename_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file test/rename_golden.txt");
      stop_run();
    end
    repeat (8) @(posedge clk_in);
    rst_in <= 1'b0;

    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd == "#") begin
        skip_line();
      end else begin
        step++;
        case (cmd)
          "D": if ($fscanf(fd, "%h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6) != 7)
                 bad_line();
               else
                 dispatch();
          "C": if ($fscanf(fd, "%h %h", f0, f1) != 2) bad_line();
               else complete();
          "W": if ($fscanf(fd, "%h %h", f0, f1) != 2) bad_line();
               else wait_commit();
          "F": do_flush();
          "S": expect_stall();
          default: begin
            $display("unknown command letter %s in the golden file", cmd);
            stop_run();
          end
        endcase
      end
    end
    go_idle();  // last dispatch gets accepted here
    $fclose(fd);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* test/rename_golden.txt */
# D word op1_value op1_ready op1_tag op2_value op2_ready op2_tag | C tag data
# W rd data | F flush | S stall expected | all fields hex
D 00500093 00000000 1 0 00000000 1 0
D 00008133 00000000 0 0 00000000 1 0
D 001101b3 00000000 0 1 00000000 0 0
C 2 0000000c
C 0 00000005
D 00308233 00000005 1 0 0000000c 1 2
W 01 00000005
C 1 00000007
W 02 00000007
W 03 0000000c
D 00108213 00000005 1 0 00000000 1 0
C 3 00000011
W 04 00000011
D 00220333 00000000 0 4 00000007 1 0
C 4 00000006
W 04 00000006
D 00620133 00000006 1 0 00000000 0 5
F
D 00610433 00000007 1 0 00000000 1 0
D 00040493 00000000 0 0 00000000 1 0
D 00048513 00000000 0 1 00000000 1 0
D 00050593 00000000 0 2 00000000 1 0
D 00058613 00000000 0 3 00000000 1 0
D 00060693 00000000 0 4 00000000 1 0
D 00068713 00000000 0 5 00000000 1 0
D 00070793 00000000 0 6 00000000 1 0
S
C 0 00000077
W 08 00000077
D 00f40833 00000077 1 0 00000000 0 7

/* vlog.f */
design/core_cfg_pkg.sv
design/rv_isa_pkg.sv
design/instr_decode.sv
design/register_file.sv
design/reorder_buffer.sv
design/operand_fetch.sv
design/rename_core.sv
test/rename_core_tb.sv
